// File: gb_pkg.sv
// shared console I/O types and constants; title range assumes a standard cartridge header
package gb_pkg;

    // one bit per button, active high
    typedef logic [7:0] btn_vec_t;

    // joypad port nibble, active low as the core reads it
    typedef logic [3:0] joy_nibble_t;

    // select lines from the core, bit 0 low picks the d-pad, bit 1 low the action buttons
    typedef logic [1:0] joy_select_t;

    typedef logic [15:0] cart_addr_t;
    typedef logic [7:0]  cart_data_t;
    typedef logic [31:0] game_hash_t;

    // positions inside btn_vec_t
    localparam int btn_right_idx  = 0;
    localparam int btn_left_idx   = 1;
    localparam int btn_up_idx     = 2;
    localparam int btn_down_idx   = 3;
    localparam int btn_a_idx      = 4;
    localparam int btn_b_idx      = 5;
    localparam int btn_select_idx = 6;
    localparam int btn_start_idx  = 7;

    // cartridge title bytes 0x0134..0x0143
    localparam cart_addr_t title_first_addr = 16'h0134;
    localparam cart_addr_t title_len        = 16'd16;

    // 32-bit FNV-1a
    localparam game_hash_t fnv_offset = 32'h811C9DC5;
    localparam game_hash_t fnv_prime  = 32'h01000193;

endpackage

// File: button_debounce.sv
// no reset on the filter; outputs settle after sr_size+1 cycles of stable input, sr_size >= 2
`timescale 1ns/10ps

module button_debounce #(
    parameter int sr_size = 15
) (
    input  logic             hclk,
    input  gb_pkg::btn_vec_t buttons,
    input  logic             btn_menu,
    input  logic             menu_closed,
    output gb_pkg::btn_vec_t filtered
);

    localparam int n_btn = $bits(gb_pkg::btn_vec_t);

    gb_pkg::btn_vec_t gated;
    logic [n_btn-1:0][sr_size-1:0] shift_q;

    // buttons belong to the menu while it is open or being called up
    assign gated = buttons & {n_btn{menu_closed & ~btn_menu}};

    always_ff @(posedge hclk) begin
        for (int i = 0; i < n_btn; i++) begin
            shift_q[i] <= {shift_q[i][sr_size-2:0], gated[i]};
        end
    end

    // the newest sample is left out so a press must hold for sr_size-1 older samples
    always_ff @(posedge hclk) begin
        for (int i = 0; i < n_btn; i++) begin
            filtered[i] <= &shift_q[i][sr_size-1:1];
        end
    end

endmodule

// File: joypad_port.sv
// no reset; joy_din is undefined until the first edge, select is sampled every cycle
`timescale 1ns/10ps

module joypad_port (
    input  logic                hclk,
    input  gb_pkg::btn_vec_t    filtered,
    input  logic                no_diagonal,
    input  gb_pkg::joy_select_t joy_select,
    output gb_pkg::joy_nibble_t joy_din
);

    logic right;
    logic left;
    logic up;
    logic down;

    // resolved d-pad as {down, up, left, right}
    logic [3:0] dir_q;
    logic [3:0] action;

    assign right = filtered[gb_pkg::btn_right_idx];
    assign left  = filtered[gb_pkg::btn_left_idx];
    assign up    = filtered[gb_pkg::btn_up_idx];
    assign down  = filtered[gb_pkg::btn_down_idx];

    assign action = {filtered[gb_pkg::btn_start_idx],
                     filtered[gb_pkg::btn_select_idx],
                     filtered[gb_pkg::btn_b_idx],
                     filtered[gb_pkg::btn_a_idx]};

    // opposite directions cancel; with no_diagonal the axis already held blocks the other
    always_ff @(posedge hclk) begin
        if (no_diagonal) begin
            dir_q[3] <= down  & ~up    & ~dir_q[1] & ~dir_q[0];
            dir_q[2] <= up    & ~down  & ~dir_q[1] & ~dir_q[0];
            dir_q[1] <= left  & ~right & ~dir_q[3] & ~dir_q[2];
            dir_q[0] <= right & ~left  & ~dir_q[3] & ~dir_q[2];
        end else begin
            dir_q[3] <= down  & ~up;
            dir_q[2] <= up    & ~down;
            dir_q[1] <= left  & ~right;
            dir_q[0] <= right & ~left;
        end
    end

    // select matrix, a low select line enables its group
    always_ff @(posedge hclk) begin
        case (joy_select)
            2'b00:   joy_din <= ~dir_q & ~action;
            2'b01:   joy_din <= ~action;
            2'b10:   joy_din <= ~dir_q;
            default: joy_din <= 4'hF;
        endcase
    end

endmodule

// File: reset_sequencer.sv
// release waits for a rising ce_2x with ce high; power_good and the button combo act at once
`timescale 1ns/10ps

module reset_sequencer (
    input  logic             hclk,
    input  logic             reset_n,
    input  logic             power_good,
    input  logic             lcd_init_done,
    input  logic             cart_rst_n,
    input  logic             ce,
    input  logic             ce_2x,
    input  logic             menu_closed,
    input  logic             btn_menu,
    input  gb_pkg::btn_vec_t buttons,
    output logic             gb_reset
);

    logic cart_rst_meta;
    logic cart_rst_sync;
    logic ce_2x_q;
    logic reset_ungated;
    logic combo;
    logic release_slot;

    // menu plus a, b, start and select held together
    assign combo = menu_closed & btn_menu
                 & buttons[gb_pkg::btn_a_idx]
                 & buttons[gb_pkg::btn_b_idx]
                 & buttons[gb_pkg::btn_start_idx]
                 & buttons[gb_pkg::btn_select_idx];

    assign release_slot = ~ce_2x_q & ce_2x & ce;

    always_ff @(posedge hclk or negedge reset_n) begin
        if (!reset_n) begin
            cart_rst_meta <= 1'b0;
            cart_rst_sync <= 1'b0;
            ce_2x_q       <= 1'b0;
            reset_ungated <= 1'b1;
            gb_reset      <= 1'b1;
        end else begin
            cart_rst_meta <= cart_rst_n;
            cart_rst_sync <= cart_rst_meta;
            ce_2x_q       <= ce_2x;
            // held in reset until the LCD is up, then the cartridge line decides
            reset_ungated <= lcd_init_done ? ~cart_rst_sync : 1'b1;

            if (!power_good || combo) begin
                gb_reset <= 1'b1;
            end else if (release_slot) begin
                gb_reset <= reset_ungated;
            end
        end
    end

endmodule

// File: header_hash.sv
// hashes each title byte once in the order first read; reads after valid are ignored
`timescale 1ns/10ps

module header_hash (
    input  logic               hclk,
    input  logic               reset_n,
    input  logic               gb_reset,
    input  gb_pkg::cart_addr_t cart_addr,
    input  gb_pkg::cart_data_t cart_data,
    input  logic               cart_rd,
    input  logic               cart_wr,
    output gb_pkg::game_hash_t game_hash,
    output logic               game_hash_valid
);

    localparam int n_title = int'(gb_pkg::title_len);
    localparam int idx_w   = $clog2(n_title);

    gb_pkg::cart_addr_t offset;
    logic [idx_w-1:0]   idx;
    logic               title_hit;
    logic               fold;
    logic [n_title-1:0] seen_q;
    logic [n_title-1:0] seen_next;
    gb_pkg::game_hash_t hash_next;

    assign offset    = cart_addr - gb_pkg::title_first_addr;
    assign idx       = offset[idx_w-1:0];
    assign title_hit = (cart_addr >= gb_pkg::title_first_addr) &&
                       (cart_addr < gb_pkg::title_first_addr + gb_pkg::title_len);

    // only the first read of each title byte counts
    assign fold      = title_hit && cart_rd && !cart_wr && !game_hash_valid && !seen_q[idx];
    assign seen_next = seen_q | (n_title'(1) << idx);
    assign hash_next = (game_hash ^ gb_pkg::game_hash_t'(cart_data)) * gb_pkg::fnv_prime;

    always_ff @(posedge hclk or negedge reset_n) begin
        if (!reset_n) begin
            game_hash       <= gb_pkg::fnv_offset;
            seen_q          <= '0;
            game_hash_valid <= 1'b0;
        end else if (gb_reset) begin
            game_hash       <= gb_pkg::fnv_offset;
            seen_q          <= '0;
            game_hash_valid <= 1'b0;
        end else if (fold) begin
            game_hash <= hash_next;
            seen_q    <= seen_next;
            // valid comes with the last missing byte
            if (&seen_next) begin
                game_hash_valid <= 1'b1;
            end
        end
    end

endmodule

// File: emu_system_top.sv
// single clock hclk; ce and ce_2x come from outside, cartridge bus is observed only
`timescale 1ns/10ps

module emu_system_top #(
    parameter int sr_size = 15
) (
    input  logic                hclk,
    input  logic                reset_n,
    input  logic                power_good,
    input  logic                lcd_init_done,
    input  logic                cart_rst_n,
    input  logic                ce,
    input  logic                ce_2x,

    input  gb_pkg::btn_vec_t    buttons,
    input  logic                btn_menu,
    input  logic                menu_closed,
    input  logic                no_diagonal,
    input  gb_pkg::joy_select_t joy_select,
    output gb_pkg::joy_nibble_t joy_din,

    input  gb_pkg::cart_addr_t  cart_addr,
    input  gb_pkg::cart_data_t  cart_data,
    input  logic                cart_rd,
    input  logic                cart_wr,

    output logic                gb_reset,
    output gb_pkg::game_hash_t  game_hash,
    output logic                game_hash_valid
);

    gb_pkg::btn_vec_t filtered;

    button_debounce #(
        .sr_size     (sr_size)
    ) u_button_debounce (
        .hclk        (hclk),
        .buttons     (buttons),
        .btn_menu    (btn_menu),
        .menu_closed (menu_closed),
        .filtered    (filtered)
    );

    joypad_port u_joypad_port (
        .hclk        (hclk),
        .filtered    (filtered),
        .no_diagonal (no_diagonal),
        .joy_select  (joy_select),
        .joy_din     (joy_din)
    );

    // the combo check sees raw buttons so it works while the menu masks them
    reset_sequencer u_reset_sequencer (
        .hclk          (hclk),
        .reset_n       (reset_n),
        .power_good    (power_good),
        .lcd_init_done (lcd_init_done),
        .cart_rst_n    (cart_rst_n),
        .ce            (ce),
        .ce_2x         (ce_2x),
        .menu_closed   (menu_closed),
        .btn_menu      (btn_menu),
        .buttons       (buttons),
        .gb_reset      (gb_reset)
    );

    header_hash u_header_hash (
        .hclk            (hclk),
        .reset_n         (reset_n),
        .gb_reset        (gb_reset),
        .cart_addr       (cart_addr),
        .cart_data       (cart_data),
        .cart_rd         (cart_rd),
        .cart_wr         (cart_wr),
        .game_hash       (game_hash),
        .game_hash_valid (game_hash_valid)
    );

endmodule

// File: tb_emu_system.sv
// single hclk testbench for sr_size 6; ce every 4th cycle, title bytes from a seed-5 LFSR
`timescale 1ns/10ps

module tb_emu_system;

    localparam int sr_size      = 6;
    localparam int row_hold     = sr_size + 4;
    localparam int n_rows       = 20;
    localparam int release_wait = 64;
    localparam int n_title      = int'(gb_pkg::title_len);

    // budget per phase, doubled for the run limit
    localparam int button_cycles = 4 + row_hold + n_rows * row_hold + 4 * row_hold;
    localparam int reset_cycles  = 3 * release_wait + 60;
    localparam int hash_cycles   = 2 * (n_title + 4 + 1) + 8;
    localparam int run_limit     = 2 * (button_cycles + reset_cycles + hash_cycles);

    typedef struct packed {
        gb_pkg::btn_vec_t    buttons;
        logic                btn_menu;
        logic                menu_closed;
        logic                no_diagonal;
        gb_pkg::joy_select_t joy_select;
        gb_pkg::joy_nibble_t joy_din;
    } stim_row_t;

    // buttons, btn_menu, menu_closed, no_diagonal, joy_select, expected joy_din
    localparam logic [16:0] stim_rows [n_rows] = '{
        {8'h00, 1'b0, 1'b1, 1'b0, 2'b11, 4'hF},
        {8'h01, 1'b0, 1'b1, 1'b0, 2'b10, 4'hE},
        {8'h01, 1'b0, 1'b1, 1'b0, 2'b01, 4'hF},
        {8'h10, 1'b0, 1'b1, 1'b0, 2'b01, 4'hE},
        {8'h10, 1'b0, 1'b1, 1'b0, 2'b10, 4'hF},
        {8'h11, 1'b0, 1'b1, 1'b0, 2'b00, 4'hE},
        {8'h12, 1'b0, 1'b1, 1'b0, 2'b00, 4'hC},
        {8'h12, 1'b0, 1'b1, 1'b0, 2'b10, 4'hD},
        {8'h12, 1'b0, 1'b1, 1'b0, 2'b01, 4'hE},
        {8'h12, 1'b0, 1'b1, 1'b0, 2'b11, 4'hF},
        {8'hC0, 1'b0, 1'b1, 1'b0, 2'b01, 4'h3},
        {8'h08, 1'b0, 1'b1, 1'b0, 2'b10, 4'h7},
        // menu button held, then menu open
        {8'h10, 1'b1, 1'b1, 1'b0, 2'b01, 4'hF},
        {8'h10, 1'b0, 1'b0, 1'b0, 2'b01, 4'hF},
        {8'h10, 1'b0, 1'b1, 1'b0, 2'b01, 4'hE},
        // up with down cancels, then down is held before left joins
        {8'h0C, 1'b0, 1'b1, 1'b0, 2'b10, 4'hF},
        {8'h08, 1'b0, 1'b1, 1'b1, 2'b10, 4'h7},
        {8'h0A, 1'b0, 1'b1, 1'b1, 2'b10, 4'h7},
        {8'h0A, 1'b0, 1'b1, 1'b0, 2'b10, 4'h5},
        {8'h00, 1'b0, 1'b1, 1'b0, 2'b10, 4'hF}
    };

    logic                hclk;
    logic                reset_n;
    logic                power_good;
    logic                lcd_init_done;
    logic                cart_rst_n;
    logic                ce = 1'b0;
    logic                ce_2x = 1'b0;
    gb_pkg::btn_vec_t    buttons;
    logic                btn_menu;
    logic                menu_closed;
    logic                no_diagonal;
    gb_pkg::joy_select_t joy_select;
    gb_pkg::joy_nibble_t joy_din;
    gb_pkg::cart_addr_t  cart_addr;
    gb_pkg::cart_data_t  cart_data;
    logic                cart_rd;
    logic                cart_wr;
    logic                gb_reset;
    gb_pkg::game_hash_t  game_hash;
    logic                game_hash_valid;

    logic [1:0]  phase = 2'd0;
    logic [15:0] lfsr_state = 16'd5;
    int          cycles = 0;
    int          tests_run = 0;
    int          errors = 0;

    emu_system_top #(
        .sr_size         (sr_size)
    ) dut0 (
        .hclk            (hclk),
        .reset_n         (reset_n),
        .power_good      (power_good),
        .lcd_init_done   (lcd_init_done),
        .cart_rst_n      (cart_rst_n),
        .ce              (ce),
        .ce_2x           (ce_2x),
        .buttons         (buttons),
        .btn_menu        (btn_menu),
        .menu_closed     (menu_closed),
        .no_diagonal     (no_diagonal),
        .joy_select      (joy_select),
        .joy_din         (joy_din),
        .cart_addr       (cart_addr),
        .cart_data       (cart_data),
        .cart_rd         (cart_rd),
        .cart_wr         (cart_wr),
        .gb_reset        (gb_reset),
        .game_hash       (game_hash),
        .game_hash_valid (game_hash_valid)
    );

    initial begin
        hclk = 1'b0;
        forever #4 hclk = ~hclk;
    end

    // ce_2x every 2nd cycle, ce every 4th on a ce_2x cycle
    always @(posedge hclk) begin
        phase <= phase + 2'd1;
        ce    <= (phase == 2'd3);
        ce_2x <= phase[0];
    end

    always @(posedge hclk) begin
        cycles <= cycles + 1;
        if (cycles == run_limit) begin
            $display("timeout: the run did not finish within %0d cycles", run_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic gb_pkg::game_hash_t fnv_fold(input gb_pkg::game_hash_t h,
                                                    input gb_pkg::cart_data_t b);
        return (h ^ {24'h000000, b}) * gb_pkg::fnv_prime;
    endfunction

    // 7 is odd, so this walks all 16 title bytes out of order
    function automatic gb_pkg::cart_addr_t title_addr(input int i);
        return gb_pkg::title_first_addr + gb_pkg::cart_addr_t'((i * 7 + 3) % n_title);
    endfunction

    task automatic next_byte(output gb_pkg::cart_data_t b);
        for (int k = 0; k < 8; k++) begin
            b[k] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_nibble(input string what, input gb_pkg::joy_nibble_t got,
                                input gb_pkg::joy_nibble_t exp);
        tests_run++;
        if (got !== exp) begin
            errors++;
            $display("error joy_din %s: got 0x%h, expected 0x%h", what, got, exp);
        end else begin
            $display("ok    %s", what);
        end
    endtask

    task automatic check_hash(input string what, input gb_pkg::game_hash_t got,
                              input gb_pkg::game_hash_t exp);
        tests_run++;
        if (got !== exp) begin
            errors++;
            $display("error game_hash %s: got 0x%h, expected 0x%h", what, got, exp);
        end else begin
            $display("ok    %s", what);
        end
    endtask

    task automatic check_level(input string what, input string signal, input logic got,
                               input logic exp);
        tests_run++;
        if (got !== exp) begin
            errors++;
            $display("error %s %s: got 0x%h, expected 0x%h", signal, what, got, exp);
        end else begin
            $display("ok    %s", what);
        end
    endtask

    task automatic apply_row(input int i);
        stim_row_t r;
        r = stim_rows[i];
        @(posedge hclk);
        buttons     <= r.buttons;
        btn_menu    <= r.btn_menu;
        menu_closed <= r.menu_closed;
        no_diagonal <= r.no_diagonal;
        joy_select  <= r.joy_select;
        repeat (sr_size + 3) @(posedge hclk);
        @(negedge hclk);
        check_nibble($sformatf("row %0d", i), joy_din, r.joy_din);
    endtask

    task automatic cart_read(input gb_pkg::cart_addr_t addr, input gb_pkg::cart_data_t data);
        @(posedge hclk);
        cart_addr <= addr;
        cart_data <= data;
        cart_rd   <= 1'b1;
        @(posedge hclk);
        cart_rd   <= 1'b0;
    endtask

    // gb_reset must fall, and only after an edge that saw ce high
    task automatic wait_release(input string what);
        logic last_ce;
        logic fell;
        int   n;
        fell    = 1'b0;
        last_ce = 1'b0;
        @(negedge hclk);
        for (n = 0; n < release_wait && !fell; n++) begin
            last_ce = ce;
            @(negedge hclk);
            if (gb_reset === 1'b0) begin
                fell = 1'b1;
            end
        end
        tests_run++;
        if (!fell) begin
            errors++;
            $display("%s: gb_reset was still high after %0d cycles", what, release_wait);
        end else if (!last_ce) begin
            errors++;
            $display("%s: gb_reset fell on an edge without ce", what);
        end else begin
            $display("ok    %s", what);
        end
    endtask

    initial begin
        gb_pkg::cart_data_t b;
        gb_pkg::game_hash_t exp_hash;
        gb_pkg::joy_nibble_t acc;
        gb_pkg::btn_vec_t combo;

        reset_n       <= 1'b0;
        power_good    <= 1'b1;
        lcd_init_done <= 1'b0;
        cart_rst_n    <= 1'b0;
        buttons       <= '0;
        btn_menu      <= 1'b0;
        menu_closed   <= 1'b1;
        no_diagonal   <= 1'b0;
        joy_select    <= 2'b11;
        cart_addr     <= '0;
        cart_data     <= '0;
        cart_rd       <= 1'b0;
        cart_wr       <= 1'b0;
        repeat (4) @(posedge hclk);
        reset_n <= 1'b1;

        // filter has no reset, let it flush with buttons released
        repeat (row_hold) @(posedge hclk);
        @(negedge hclk);
        check_level("gb_reset after reset", "gb_reset", gb_reset, 1'b1);
        check_level("valid after reset", "game_hash_valid", game_hash_valid, 1'b0);
        check_hash("hash after reset", game_hash, gb_pkg::fnv_offset);

        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end

        // a press of sr_size-2 cycles never reaches joy_din
        @(posedge hclk);
        joy_select <= 2'b01;
        buttons    <= 8'h10;
        repeat (sr_size - 2) @(posedge hclk);
        buttons <= 8'h00;
        acc = 4'hF;
        repeat (row_hold) begin
            @(negedge hclk);
            acc = acc & joy_din;
        end
        check_nibble("short press on a", acc, 4'hF);

        @(posedge hclk);
        buttons <= 8'h10;
        repeat (sr_size + 3) @(posedge hclk);
        @(negedge hclk);
        check_nibble("a held on select 01", joy_din, 4'hE);
        @(posedge hclk);
        joy_select <= 2'b10;
        @(negedge hclk);
        check_nibble("select change before the edge", joy_din, 4'hE);
        @(negedge hclk);
        check_nibble("select change one edge later", joy_din, 4'hF);
        @(posedge hclk);
        buttons <= 8'h00;

        @(posedge hclk);
        cart_rst_n <= 1'b1;
        repeat (16) @(posedge hclk);
        @(negedge hclk);
        check_level("gb_reset before lcd init", "gb_reset", gb_reset, 1'b1);
        // cartridge back into reset before the lcd comes up
        @(posedge hclk);
        cart_rst_n <= 1'b0;
        repeat (4) @(posedge hclk);
        lcd_init_done <= 1'b1;
        repeat (16) @(posedge hclk);
        @(negedge hclk);
        check_level("gb_reset with cartridge in reset", "gb_reset", gb_reset, 1'b1);
        @(posedge hclk);
        cart_rst_n <= 1'b1;
        wait_release("release after lcd and cartridge");

        exp_hash = gb_pkg::fnv_offset;
        for (int i = 0; i < n_title; i++) begin
            next_byte(b);
            cart_read(title_addr(i), b);
            exp_hash = fnv_fold(exp_hash, b);
            if (i % 4 == 3 && i != n_title - 1) begin
                next_byte(b);
                cart_read(title_addr(i - 2), b);
            end
            if (i == n_title - 2) begin
                @(negedge hclk);
                check_level("valid before last title byte", "game_hash_valid",
                            game_hash_valid, 1'b0);
            end
        end
        @(negedge hclk);
        check_hash("title hash", game_hash, exp_hash);
        check_level("valid after all title bytes", "game_hash_valid", game_hash_valid, 1'b1);
        next_byte(b);
        cart_read(title_addr(5), b);
        @(negedge hclk);
        check_hash("hash after a later read", game_hash, exp_hash);

        @(posedge hclk);
        power_good <= 1'b0;
        @(posedge hclk);
        @(negedge hclk);
        check_level("gb_reset on power loss", "gb_reset", gb_reset, 1'b1);
        @(negedge hclk);
        check_level("valid cleared by reset", "game_hash_valid", game_hash_valid, 1'b0);
        check_hash("hash cleared by reset", game_hash, gb_pkg::fnv_offset);
        @(posedge hclk);
        power_good <= 1'b1;
        wait_release("release after power good");

        combo = '0;
        combo[gb_pkg::btn_a_idx]      = 1'b1;
        combo[gb_pkg::btn_b_idx]      = 1'b1;
        combo[gb_pkg::btn_start_idx]  = 1'b1;
        combo[gb_pkg::btn_select_idx] = 1'b1;
        @(posedge hclk);
        buttons  <= combo;
        btn_menu <= 1'b1;
        @(posedge hclk);
        @(negedge hclk);
        check_level("gb_reset on button combo", "gb_reset", gb_reset, 1'b1);
        @(posedge hclk);
        buttons  <= 8'h00;
        btn_menu <= 1'b0;
        wait_release("release after button combo");

        $display("tests: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: files.f
gb_pkg.sv
button_debounce.sv
joypad_port.sv
reset_sequencer.sv
header_hash.sv
emu_system_top.sv
tb_emu_system.sv

// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_emu_system: files.f $(SRCS)
	verilator --binary --timing -j 0 -f files.f --top-module tb_emu_system

run: obj_dir/Vtb_emu_system
	@out="$$(./obj_dir/Vtb_emu_system)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf obj_dir
